// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= sense_tb
FILELIST  ?= list.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: include/sense_defs.svh
`ifndef SENSE_DEFS_SVH
`define SENSE_DEFS_SVH

////////////////////
// host bus
////////////////////

// byte address, four registers
`define SENSE_AXI_ADDR_W 4
`define SENSE_AXI_DATA_W 32

////////////////////
// serial timing
////////////////////

// system clocks per sck half period
`define SENSE_SCK_DIV 4

// idle sck clocks ahead of each sample and at the frame end
`define SENSE_ADC_PAD 2

// sample period in system clocks
`define SENSE_PERIOD_RESET 2000
// must stay above convert pulse plus one full frame
`define SENSE_PERIOD_MIN 320

`endif

// File: list.f
+incdir+include
logic/sense_pkg.sv
logic/spi_shifter.sv
logic/amp_gain_spi.sv
logic/adc_capture.sv
logic/sense_ctrl.sv
logic/sense_top.sv
verif/spi_devices.sv
verif/sense_tb.sv

// File: logic/adc_capture.sv
`include "sense_defs.svh"

// dual adc capture
// convert pulse of one sck period, then one full frame read back
module adc_capture (
	input  logic               clk50mhz,
	input  logic               rst_n,
	input  logic               start,
	input  logic               adc_out,
	output sense_pkg::sample_t sample_a,
	output sense_pkg::sample_t sample_b,
	output logic               busy,
	output logic               done,
	output logic               adc_conv,
	output logic               sck,
	output logic               mosi
);

	localparam int CONV_CLKS = 2 * `SENSE_SCK_DIV;
	localparam int CONV_W = $clog2(CONV_CLKS + 1);
	localparam logic [CONV_W-1:0] CONV_LAST = CONV_W'(CONV_CLKS - 1);

	typedef enum logic [1:0] {S_IDLE, S_CONV, S_SHIFT} state_e;

	state_e                state;
	logic [CONV_W-1:0]     conv_cnt;
	sense_pkg::adc_frame_t frame;
	logic                  sh_start;
	logic                  sh_done;

	// frame read starts as the convert pulse ends
	assign sh_start = (state == S_CONV) && (conv_cnt == CONV_LAST);
	assign busy = (state != S_IDLE);

	////////////////////
	// frame shifter
	////////////////////

	// adc ignores its data input, shift out zeros
	spi_shifter #(
		.payload_t(sense_pkg::adc_frame_t)
	) u_shifter (
		.clk50mhz(clk50mhz),
		.rst_n   (rst_n),
		.start   (sh_start),
		.tx_data ('0),
		.miso    (adc_out),
		.rx_data (frame),
		.busy    (),
		.done    (sh_done),
		.sck     (sck),
		.mosi    (mosi)
	);

	////////////////////
	// sequencing
	////////////////////

	always_ff @(posedge clk50mhz) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			adc_conv <= 1'b0;
			conv_cnt <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: if (start) begin
					adc_conv <= 1'b1;
					conv_cnt <= '0;
					state    <= S_CONV;
				end
				S_CONV: begin
					conv_cnt <= conv_cnt + 1'b1;
					if (sh_start) begin
						adc_conv <= 1'b0;
						state    <= S_SHIFT;
					end
				end
				S_SHIFT: if (sh_done) begin
					done  <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// pad bits dropped here
	always_ff @(posedge clk50mhz) begin
		if (sh_done) begin
			sample_a <= frame.sample_a;
			sample_b <= frame.sample_b;
		end
	end

endmodule

// File: logic/amp_gain_spi.sv
// preamp gain loader
// cs framed around the shifter with one setup and one hold cycle
module amp_gain_spi (
	input  logic                 clk50mhz,
	input  logic                 rst_n,
	input  logic                 start,
	input  sense_pkg::amp_word_t gain_word,
	input  logic                 amp_dout,
	output sense_pkg::amp_word_t echo_word,
	output logic                 busy,
	output logic                 done,
	output logic                 amp_cs,
	output logic                 sck,
	output logic                 mosi
);

	typedef enum logic [2:0] {S_IDLE, S_SETUP, S_SHIFT, S_HOLD, S_FIN} state_e;

	state_e               state;
	sense_pkg::amp_word_t word_q;
	sense_pkg::amp_word_t sh_rx;
	logic                 sh_start;
	logic                 sh_done;

	// shifter kicked off one cycle after cs falls
	assign sh_start = (state == S_SETUP);
	assign busy = (state != S_IDLE);

	spi_shifter #(
		.payload_t(sense_pkg::amp_word_t)
	) u_shifter (
		.clk50mhz(clk50mhz),
		.rst_n   (rst_n),
		.start   (sh_start),
		.tx_data (word_q),
		.miso    (amp_dout),
		.rx_data (sh_rx),
		.busy    (),
		.done    (sh_done),
		.sck     (sck),
		.mosi    (mosi)
	);

	always_ff @(posedge clk50mhz) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			amp_cs    <= 1'b1;
			done      <= 1'b0;
			echo_word <= '0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: if (start) begin
					amp_cs <= 1'b0;
					state  <= S_SETUP;
				end
				S_SETUP: state <= S_SHIFT;
				S_SHIFT: if (sh_done) begin
					// previous word as echoed by the preamp
					echo_word <= sh_rx;
					state     <= S_HOLD;
				end
				// preamp latches the new gains on the cs rise
				S_HOLD: begin
					amp_cs <= 1'b1;
					state  <= S_FIN;
				end
				S_FIN: begin
					done  <= 1'b1;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word held for the shifter load one cycle later
	always_ff @(posedge clk50mhz) begin
		if (state == S_IDLE && start) begin
			word_q <= gain_word;
		end
	end

endmodule

// File: logic/sense_ctrl.sv
`include "sense_defs.svh"

// register file, sample timer and serial bus arbiter
module sense_ctrl (
	input  logic                         clk50mhz,
	input  logic                         rst_n,
	// axi4-lite slave
	input  logic [`SENSE_AXI_ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`SENSE_AXI_DATA_W-1:0] wdata,
	input  logic                         wvalid,
	output logic                         wready,
	output logic                         bvalid,
	input  logic                         bready,
	output logic [1:0]                   bresp,
	input  logic [`SENSE_AXI_ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic                         rvalid,
	input  logic                         rready,
	output logic [`SENSE_AXI_DATA_W-1:0] rdata,
	output logic [1:0]                   rresp,
	// gain writer
	output logic                         amp_start,
	output sense_pkg::amp_word_t         amp_word,
	input  logic                         amp_busy,
	input  logic                         amp_done,
	input  sense_pkg::amp_word_t         amp_echo,
	input  logic                         amp_sck,
	input  logic                         amp_mosi,
	output logic                         amp_shdn,
	// adc capture
	output logic                         adc_start,
	input  logic                         adc_busy,
	input  logic                         adc_done,
	input  sense_pkg::sample_t           adc_a,
	input  sense_pkg::sample_t           adc_b,
	input  logic                         adc_sck,
	input  logic                         adc_mosi,
	// shared serial bus
	output logic                         spi_sck,
	output logic                         spi_mosi
);

	localparam int DW = `SENSE_AXI_DATA_W;
	localparam logic [DW-1:0] PERIOD_MIN = DW'(`SENSE_PERIOD_MIN);

	logic                 ctrl_en, ctrl_shdn;
	logic [DW-1:0]        period_q, eff_period, tmr_cnt;
	sense_pkg::amp_word_t echo_q;
	logic                 gain_pend, amp_act, adc_act;
	logic                 tick, tick_wait, bus_free;
	sense_pkg::sample_t   samp_a_q, samp_b_q;
	logic                 samp_valid;
	logic                 wr_hs, rd_hs;
	sense_pkg::reg_addr_e wr_reg, rd_reg;
	logic [DW-1:0]        rd_word;

	////////////////////
	// host side
	////////////////////

	// address and data taken in one beat, low address bits dropped
	assign wr_hs = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready = wr_hs;
	assign arready = !rvalid;
	assign rd_hs = arvalid && !rvalid;
	assign wr_reg = sense_pkg::reg_addr_e'({awaddr[`SENSE_AXI_ADDR_W-1:2], 2'b00});
	assign rd_reg = sense_pkg::reg_addr_e'({araddr[`SENSE_AXI_ADDR_W-1:2], 2'b00});
	// always okay
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	always_comb begin
		rd_word = '0;
		case (rd_reg)
			sense_pkg::REG_CTRL: rd_word[1:0] = {ctrl_shdn, ctrl_en};
			sense_pkg::REG_PERIOD: rd_word = period_q;
			sense_pkg::REG_GAIN: rd_word[16:0] = {gain_pend || amp_act, echo_q, amp_word};
			// each sample sign extended through its half word
			sense_pkg::REG_SAMPLE: begin
				rd_word[15:0] = {{2{samp_a_q[13]}}, samp_a_q};
				rd_word[30:16] = {samp_b_q[13], samp_b_q};
				rd_word[31] = samp_valid;
			end
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk50mhz) begin
		if (!rst_n) begin
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
			ctrl_en   <= 1'b0;
			ctrl_shdn <= 1'b0;
			period_q  <= DW'(`SENSE_PERIOD_RESET);
			amp_word  <= '0;
		end else begin
			if (wr_hs) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_hs) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			// sample and unknown offsets fall through
			if (wr_hs) begin
				case (wr_reg)
					sense_pkg::REG_CTRL: {ctrl_shdn, ctrl_en} <= wdata[1:0];
					sense_pkg::REG_PERIOD: period_q <= wdata;
					sense_pkg::REG_GAIN: amp_word <= wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	// read data held until rready
	always_ff @(posedge clk50mhz) begin
		if (rd_hs) begin
			rdata <= rd_word;
		end
	end

	////////////////////
	// timer, arbiter
	////////////////////

	assign eff_period = (period_q < PERIOD_MIN) ? PERIOD_MIN : period_q;
	// >= covers a period shortened mid count
	assign tick = ctrl_en && (tmr_cnt >= eff_period - 1'b1);
	assign bus_free = !amp_act && !adc_act;
	// gain writes go first
	assign amp_start = gain_pend && bus_free;
	assign adc_start = (tick || tick_wait) && bus_free && !gain_pend;
	assign amp_shdn = ctrl_shdn;
	// idle engines hold sck low
	assign spi_sck = amp_busy ? amp_sck : (adc_busy ? adc_sck : 1'b0);
	assign spi_mosi = amp_busy ? amp_mosi : (adc_busy ? adc_mosi : 1'b0);

	always_ff @(posedge clk50mhz) begin
		if (!rst_n) begin
			tmr_cnt    <= '0;
			tick_wait  <= 1'b0;
			gain_pend  <= 1'b0;
			amp_act    <= 1'b0;
			adc_act    <= 1'b0;
			echo_q     <= '0;
			samp_valid <= 1'b0;
		end else begin
			if (!ctrl_en || tick) begin
				tmr_cnt <= '0;
			end else begin
				tmr_cnt <= tmr_cnt + 1'b1;
			end
			// a single waiting tick, extras are lost
			if (!ctrl_en || adc_start) begin
				tick_wait <= 1'b0;
			end else if (tick) begin
				tick_wait <= 1'b1;
			end
			// a write during a start queues another transfer
			if (wr_hs && wr_reg == sense_pkg::REG_GAIN) begin
				gain_pend <= 1'b1;
			end else if (amp_start) begin
				gain_pend <= 1'b0;
			end
			if (amp_start) begin
				amp_act <= 1'b1;
			end else if (amp_done) begin
				amp_act <= 1'b0;
				echo_q  <= amp_echo;
			end
			if (adc_start) begin
				adc_act <= 1'b1;
			end else if (adc_done) begin
				adc_act <= 1'b0;
			end
			// fresh frame beats a read in the same cycle
			if (adc_done) begin
				samp_valid <= 1'b1;
			end else if (rd_hs && rd_reg == sense_pkg::REG_SAMPLE) begin
				samp_valid <= 1'b0;
			end
		end
	end

	// newest frame overwrites unread data
	always_ff @(posedge clk50mhz) begin
		if (adc_done) begin
			samp_a_q <= adc_a;
			samp_b_q <= adc_b;
		end
	end

endmodule

// File: logic/sense_pkg.sv
`include "sense_defs.svh"

package sense_pkg;

	// gain code for one preamp channel
	typedef logic [3:0] gain_t;

	// two's complement conversion result
	typedef logic signed [13:0] sample_t;

	// word as shifted into the preamp
	// channel b sits in the high nibble
	typedef struct packed {
		gain_t gain_b;
		gain_t gain_a;
	} amp_word_t;

	// one adc frame, first bit on the wire is the msb
	typedef struct packed {
		logic [`SENSE_ADC_PAD-1:0] pad_lead;
		sample_t                   sample_a;
		logic [`SENSE_ADC_PAD-1:0] pad_mid;
		sample_t                   sample_b;
		logic [`SENSE_ADC_PAD-1:0] pad_tail;
	} adc_frame_t;

	// register byte offsets
	typedef enum logic [`SENSE_AXI_ADDR_W-1:0] {
		REG_CTRL   = 'h0,
		REG_PERIOD = 'h4,
		REG_GAIN   = 'h8,
		REG_SAMPLE = 'hc
	} reg_addr_e;

endpackage

// File: logic/sense_top.sv
`include "sense_defs.svh"

// two channel front end, host on axi4-lite
module sense_top (
	input  logic                         clk50mhz,
	input  logic                         rst_n,
	// host bus
	input  logic [`SENSE_AXI_ADDR_W-1:0] awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`SENSE_AXI_DATA_W-1:0] wdata,
	input  logic                         wvalid,
	output logic                         wready,
	output logic                         bvalid,
	input  logic                         bready,
	output logic [1:0]                   bresp,
	input  logic [`SENSE_AXI_ADDR_W-1:0] araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic                         rvalid,
	input  logic                         rready,
	output logic [`SENSE_AXI_DATA_W-1:0] rdata,
	output logic [1:0]                   rresp,
	// shared serial bus
	output logic                         spi_sck,
	output logic                         spi_mosi,
	// preamp
	output logic                         amp_cs,
	output logic                         amp_shdn,
	input  logic                         amp_dout,
	// adc
	output logic                         ad_conv,
	input  logic                         adc_out
);

	// gain writer side
	logic                 amp_start, amp_busy, amp_done;
	sense_pkg::amp_word_t amp_word, amp_echo;
	logic                 amp_sck, amp_mosi;
	// adc side
	logic                 adc_start, adc_busy, adc_done;
	sense_pkg::sample_t   adc_a, adc_b;
	logic                 adc_sck, adc_mosi;

	sense_ctrl u_ctrl (
		.clk50mhz (clk50mhz),
		.rst_n    (rst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bvalid   (bvalid),
		.bready   (bready),
		.bresp    (bresp),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rvalid   (rvalid),
		.rready   (rready),
		.rdata    (rdata),
		.rresp    (rresp),
		.amp_start(amp_start),
		.amp_word (amp_word),
		.amp_busy (amp_busy),
		.amp_done (amp_done),
		.amp_echo (amp_echo),
		.amp_sck  (amp_sck),
		.amp_mosi (amp_mosi),
		.amp_shdn (amp_shdn),
		.adc_start(adc_start),
		.adc_busy (adc_busy),
		.adc_done (adc_done),
		.adc_a    (adc_a),
		.adc_b    (adc_b),
		.adc_sck  (adc_sck),
		.adc_mosi (adc_mosi),
		.spi_sck  (spi_sck),
		.spi_mosi (spi_mosi)
	);

	amp_gain_spi u_amp (
		.clk50mhz (clk50mhz),
		.rst_n    (rst_n),
		.start    (amp_start),
		.gain_word(amp_word),
		.amp_dout (amp_dout),
		.echo_word(amp_echo),
		.busy     (amp_busy),
		.done     (amp_done),
		.amp_cs   (amp_cs),
		.sck      (amp_sck),
		.mosi     (amp_mosi)
	);

	adc_capture u_adc (
		.clk50mhz(clk50mhz),
		.rst_n   (rst_n),
		.start   (adc_start),
		.adc_out (adc_out),
		.sample_a(adc_a),
		.sample_b(adc_b),
		.busy    (adc_busy),
		.done    (adc_done),
		.adc_conv(ad_conv),
		.sck     (adc_sck),
		.mosi    (adc_mosi)
	);

endmodule

// File: logic/spi_shifter.sv
`include "sense_defs.svh"

// mode 0 engine, sck idles low
// mosi moves after falling edges, miso taken on rising edges
module spi_shifter #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk50mhz,
	input  logic     rst_n,
	input  logic     start,
	input  payload_t tx_data,
	input  logic     miso,
	output payload_t rx_data,
	output logic     busy,
	output logic     done,
	output logic     sck,
	output logic     mosi
);

	localparam int NBITS = $bits(payload_t);
	localparam int DIV_W = $clog2(`SENSE_SCK_DIV + 1);
	localparam int CNT_W = $clog2(NBITS + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SENSE_SCK_DIV - 1);
	localparam logic [CNT_W-1:0] BIT_ALL = CNT_W'(NBITS);

	logic [DIV_W-1:0] div_cnt;
	logic [CNT_W-1:0] bit_cnt;
	logic [NBITS-1:0] shreg;
	logic [NBITS-1:0] tx_bits;
	logic             edge_due;

	assign tx_bits = tx_data;
	// half period elapsed, sck toggles this cycle
	assign edge_due = busy && (div_cnt == DIV_LAST);
	assign rx_data = payload_t'(shreg);

	always_ff @(posedge clk50mhz) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			sck     <= 1'b0;
			mosi    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				div_cnt <= '0;
				bit_cnt <= '0;
				if (start) begin
					busy <= 1'b1;
					// first bit is set up a full half period before the rise
					mosi <= tx_bits[NBITS-1];
				end
			end else if (!edge_due) begin
				div_cnt <= div_cnt + 1'b1;
			end else begin
				div_cnt <= '0;
				sck     <= ~sck;
				if (!sck) begin
					// rising edge, one more bit taken in
					bit_cnt <= bit_cnt + 1'b1;
				end else if (bit_cnt == BIT_ALL) begin
					// last falling edge ends the transfer
					busy <= 1'b0;
					done <= 1'b1;
					mosi <= 1'b0;
				end else begin
					mosi <= shreg[NBITS-1];
				end
			end
		end
	end

	// one register shifts out and in at once
	always_ff @(posedge clk50mhz) begin
		if (!busy && start) begin
			shreg <= tx_bits;
		end else if (edge_due && !sck) begin
			shreg <= {shreg[NBITS-2:0], miso};
		end
	end

endmodule

// File: verif/sense_tb.sv
`include "sense_defs.svh"

module sense_tb;

	localparam int WAIT_LIMIT = 20000;

	logic                         clk50mhz;
	logic                         rst_n;
	logic [`SENSE_AXI_ADDR_W-1:0] awaddr, araddr;
	logic                         awvalid, wvalid, bready, arvalid, rready;
	logic [`SENSE_AXI_DATA_W-1:0] wdata, rdata, rdata_q;
	logic                         awready, wready, bvalid, arready, rvalid;
	logic [1:0]                   bresp, rresp;
	logic                         spi_sck, spi_mosi, amp_cs, amp_shdn, amp_dout;
	logic                         ad_conv, adc_out;
	logic [7:0]                   amp_word;
	logic                         push, adc_sel, hold_b, hold_r;
	logic [13:0]                  push_a, push_b, served_a, served_b;
	logic [31:0]                  lfsr_state;

	sense_top DUT (
		.clk50mhz(clk50mhz), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi),
		.amp_cs(amp_cs), .amp_shdn(amp_shdn), .amp_dout(amp_dout),
		.ad_conv(ad_conv), .adc_out(adc_out)
	);

	amp_model u_amp (
		.amp_cs(amp_cs), .sck(spi_sck), .mosi(spi_mosi),
		.amp_dout(amp_dout), .word(amp_word)
	);

	adc_model u_adc (
		.clk(clk50mhz), .push(push), .push_a(push_a), .push_b(push_b),
		.ad_conv(ad_conv), .sck(spi_sck), .adc_out(adc_out),
		.served_a(served_a), .served_b(served_b), .frame_act(adc_sel)
	);

	always #10 clk50mhz = ~clk50mhz;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("mismatch at %0t: %s", $time, what));
	endtask

	// galois lfsr, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// sample register layout, each value sign extended in its field
	function automatic logic [31:0] sample_word(input logic [13:0] a, input logic [13:0] b);
		logic [31:0] w;
		w = '0;
		w[13:0] = a;
		w[15:14] = {2{a[13]}};
		w[29:16] = b;
		w[30] = b[13];
		w[31] = 1'b1;
		return w;
	endfunction

	////////////////////
	// bus checks
	////////////////////

	always @(posedge clk50mhz) begin
		if (rst_n) begin
			assert (amp_cs || !ad_conv)
				else abort_run("preamp selected while the adc converts");
			assert (!spi_sck || !amp_cs || ad_conv || adc_sel)
				else abort_run("sck toggled with no device selected");
			// address and data accepted in the same beat
			assert (awready == wready)
				else report_mismatch($sformatf("awready %b, wready %b", awready, wready));
			// every response is okay
			if (bvalid) begin
				assert (bresp == 2'b00)
					else report_mismatch($sformatf("bresp %b, expected 00", bresp));
			end
			if (rvalid) begin
				assert (rresp == 2'b00)
					else report_mismatch($sformatf("rresp %b, expected 00", rresp));
			end
			if (hold_b) begin
				assert (bvalid) else abort_run("bvalid dropped before bready");
			end
			if (hold_r) begin
				assert (rvalid) else abort_run("rvalid dropped before rready");
				assert (rdata == rdata_q)
					else report_mismatch($sformatf("rdata %h changed to %h", rdata_q, rdata));
			end
		end
		hold_b <= bvalid && !bready;
		hold_r <= rvalid && !rready;
		rdata_q <= rdata;
	end

	////////////////////
	// host tasks
	////////////////////

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		int cnt;
		cnt = 0;
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do begin
			@(posedge clk50mhz);
			cnt++;
			if (cnt > WAIT_LIMIT) abort_run("timeout waiting for awready");
		end while (!awready);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		// random back-pressure on the response
		repeat (take_bits(3)) @(posedge clk50mhz);
		bready <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk50mhz);
			cnt++;
			if (cnt > WAIT_LIMIT) abort_run("timeout waiting for bvalid");
		end while (!(bvalid && bready));
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		int cnt;
		cnt = 0;
		araddr <= addr;
		arvalid <= 1'b1;
		do begin
			@(posedge clk50mhz);
			cnt++;
			if (cnt > WAIT_LIMIT) abort_run("timeout waiting for arready");
		end while (!arready);
		arvalid <= 1'b0;
		repeat (take_bits(3)) @(posedge clk50mhz);
		rready <= 1'b1;
		cnt = 0;
		do begin
			@(posedge clk50mhz);
			cnt++;
			if (cnt > WAIT_LIMIT) abort_run("timeout waiting for rvalid");
		end while (!(rvalid && rready));
		data = rdata;
		rready <= 1'b0;
	endtask

	// gain write, then wait for the transfer and check both bytes
	task automatic write_gain(input logic [7:0] w, inout logic [7:0] prev);
		logic [31:0] rd;
		int          cnt;
		cnt = 0;
		axi_write(sense_pkg::REG_GAIN, {24'h0, w});
		do begin
			axi_read(sense_pkg::REG_GAIN, rd);
			cnt++;
			if (cnt > 200) abort_run("timeout waiting for the gain transfer");
		end while (rd[16]);
		assert (amp_word == w)
			else report_mismatch($sformatf("preamp got %h, expected %h", amp_word, w));
		assert (rd[15:0] == {prev, w})
			else report_mismatch($sformatf("GAIN read %h, expected %h", rd[15:0], {prev, w}));
		prev = w;
	endtask

	// cycles until the next convert rise
	task automatic wait_conv_rise(output int gap);
		logic last;
		logic seen;
		last = ad_conv;
		gap = 0;
		do begin
			@(posedge clk50mhz);
			gap++;
			seen = ad_conv && !last;
			last = ad_conv;
			if (gap > WAIT_LIMIT) abort_run("timeout waiting for a convert pulse");
		end while (!seen);
	endtask

	task automatic check_period(input logic [31:0] p);
		int gap;
		int expect_gap;
		logic [31:0] rd;
		expect_gap = (p < `SENSE_PERIOD_MIN) ? `SENSE_PERIOD_MIN : p;
		axi_write(sense_pkg::REG_PERIOD, p);
		axi_read(sense_pkg::REG_PERIOD, rd);
		assert (rd == p) else report_mismatch($sformatf("PERIOD read %0d, wrote %0d", rd, p));
		// first interval may straddle the write
		wait_conv_rise(gap);
		wait_conv_rise(gap);
		wait_conv_rise(gap);
		assert (gap == expect_gap)
			else report_mismatch($sformatf("convert gap %0d, expected %0d", gap, expect_gap));
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial begin
		logic [31:0] rd;
		logic [31:0] want;
		logic [7:0]  prev;
		int          cnt;
		clk50mhz = 1'b0;
		rst_n = 1'b0;
		awaddr = '0;
		araddr = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		push = 1'b0;
		push_a = '0;
		push_b = '0;
		hold_b = 1'b0;
		hold_r = 1'b0;
		rdata_q = '0;
		lfsr_state = 32'h41b1cfab;
		prev = '0;
		repeat (16) @(posedge clk50mhz);
		assert (amp_cs && !ad_conv && !spi_sck && !amp_shdn)
			else abort_run("device pins not idle during reset");
		rst_n <= 1'b1;

		// sample pairs for the adc model
		for (int i = 0; i < 64; i++) begin
			push <= 1'b1;
			push_a <= take_bits(14);
			push_b <= take_bits(14);
			@(posedge clk50mhz);
		end
		push <= 1'b0;

		axi_read(sense_pkg::REG_CTRL, rd);
		assert (rd == 0) else report_mismatch($sformatf("CTRL after reset %h", rd));
		axi_read(sense_pkg::REG_PERIOD, rd);
		assert (rd == `SENSE_PERIOD_RESET)
			else report_mismatch($sformatf("PERIOD after reset %0d", rd));
		axi_read(sense_pkg::REG_SAMPLE, rd);
		assert (!rd[31]) else report_mismatch("SAMPLE valid after reset");

		// gain path, sampling off
		for (int i = 0; i < 6; i++) begin
			write_gain(take_bits(8), prev);
		end

		// sample path
		axi_write(sense_pkg::REG_CTRL, 32'h1);
		cnt = 0;
		do begin
			axi_read(sense_pkg::REG_SAMPLE, rd);
			cnt++;
			if (cnt > 2000) abort_run("timeout waiting for a valid sample");
		end while (!rd[31]);
		want = sample_word(served_a, served_b);
		assert (rd == want) else report_mismatch($sformatf("SAMPLE %h, expected %h", rd, want));
		axi_read(sense_pkg::REG_SAMPLE, rd);
		assert (!rd[31]) else report_mismatch("SAMPLE valid not cleared by the read");
		axi_write(sense_pkg::REG_CTRL, 32'h3);
		@(posedge clk50mhz);
		assert (amp_shdn) else report_mismatch("amp_shdn low with CTRL bit 1 set");

		// period, one above and one below the minimum
		check_period(`SENSE_PERIOD_MIN + 1 + take_bits(9));
		check_period(take_bits(8));

		// gain writes racing the sample timer
		for (int i = 0; i < 8; i++) begin
			repeat (take_bits(8)) @(posedge clk50mhz);
			write_gain(take_bits(8), prev);
		end

		axi_write(sense_pkg::REG_CTRL, 32'h0);
		$display("Test OK");
		$finish;
	end

endmodule

// File: verif/spi_devices.sv
// preamp model
// echoes the stored word while taking the new one, latched on the cs rise
module amp_model (
	input  logic       amp_cs,
	input  logic       sck,
	input  logic       mosi,
	output logic       amp_dout,
	output logic [7:0] word
);

	logic [7:0] in_sr;
	logic [7:0] out_sr;

	initial begin
		in_sr = '0;
		out_sr = '0;
		word = '0;
		amp_dout = 1'b0;
	end

	// first echo bit ready before the first rise
	always @(negedge amp_cs) begin
		out_sr = word;
		amp_dout = out_sr[7];
	end

	always @(posedge sck) begin
		if (!amp_cs) begin
			in_sr = {in_sr[6:0], mosi};
		end
	end

	always @(negedge sck) begin
		if (!amp_cs) begin
			out_sr = out_sr << 1;
			amp_dout = out_sr[7];
		end
	end

	always @(posedge amp_cs) begin
		word = in_sr;
	end

endmodule

// dual adc model, one queued sample pair per convert pulse
module adc_model (
	input  logic        clk,
	input  logic        push,
	input  logic [13:0] push_a,
	input  logic [13:0] push_b,
	input  logic        ad_conv,
	input  logic        sck,
	output logic        adc_out,
	output logic [13:0] served_a,
	output logic [13:0] served_b,
	output logic        frame_act
);

	logic [27:0] pairs[$];
	logic [33:0] out_sr;
	int          edges;

	initial begin
		adc_out = 1'b0;
		served_a = '0;
		served_b = '0;
		frame_act = 1'b0;
		out_sr = '0;
		edges = 0;
	end

	always @(posedge clk) begin
		if (push) begin
			pairs.push_back({push_a, push_b});
		end
	end

	// empty queue serves zeros
	always @(posedge ad_conv) begin
		logic [27:0] p;
		p = (pairs.size() > 0) ? pairs.pop_front() : '0;
		served_a = p[27:14];
		served_b = p[13:0];
		out_sr = {2'b00, p[27:14], 2'b00, p[13:0], 2'b00};
		adc_out = out_sr[33];
		frame_act = 1'b1;
		edges = 0;
	end

	// frame ends on its 34th falling edge
	always @(negedge sck) begin
		if (frame_act) begin
			out_sr = out_sr << 1;
			adc_out = out_sr[33];
			edges = edges + 1;
			if (edges == 34) begin
				frame_act = 1'b0;
			end
		end
	end

endmodule
